//--- Bender.yml
package:
  name: dbus_dmem

sources:
  - rtl/dbus_pkg.sv
  - rtl/dmem.sv
  - rtl/core_req_buffer.sv
  - rtl/rr_arbiter.sv
  - rtl/reservation_table.sv
  - rtl/access_lane.sv
  - rtl/dbus_dmem.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/dbus_dmem_assert.sv
      - test/tb_dbus_dmem.sv

//--- all.f
rtl/dbus_pkg.sv
rtl/dmem.sv
rtl/core_req_buffer.sv
rtl/rr_arbiter.sv
rtl/reservation_table.sv
rtl/access_lane.sv
rtl/dbus_dmem.sv
test/clk_gen.sv
test/dbus_dmem_assert.sv
test/tb_dbus_dmem.sv

//--- rtl/access_lane.sv
`timescale 1ns/100ps

module access_lane (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    input  logic                                   grant_valid_i,
    input  dbus_pkg::core_idx_t                    grant_core_i,
    input  logic [dbus_pkg::NCORES-1:0]            pend_re_i,
    input  logic [dbus_pkg::NCORES-1:0]            pend_we_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] pend_addr_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] pend_wdata_i,
    input  dbus_pkg::strb_t [dbus_pkg::NCORES-1:0] pend_wstrb_i,
    input  logic [dbus_pkg::NCORES-1:0]            pend_lr_i,
    input  logic [dbus_pkg::NCORES-1:0]            pend_sc_i,
    input  logic                                   sc_ok_i,
    input  dbus_pkg::word_t                        mem_rdata_i,
    output logic                                   serve_o,
    output dbus_pkg::core_idx_t                    serve_core_o,
    output logic                                   advance_o,
    output dbus_pkg::core_idx_t                    advance_core_o,
    output logic                                   lr_set_o,
    output logic                                   sc_check_o,
    output logic                                   store_inval_o,
    output dbus_pkg::core_idx_t                    rsv_core_o,
    output dbus_pkg::word_t                        rsv_addr_o,
    output logic                                   mem_re_o,
    output logic                                   mem_we_o,
    output dbus_pkg::word_t                        mem_addr_o,
    output dbus_pkg::word_t                        mem_wdata_o,
    output dbus_pkg::strb_t                        mem_wstrb_o,
    output dbus_pkg::word_t [dbus_pkg::NCORES-1:0] rdata_o,
    output logic [dbus_pkg::NCORES-1:0]            rdata_valid_o
);
    import dbus_pkg::*;

    lane_state_t state_q;
    lane_state_t state_d;
    core_idx_t   sel_q;
    core_idx_t   sel_d;
    logic        in_rsv;
    logic        in_acc;
    logic        ret_valid_q;
    logic        ret_sc_q;
    core_idx_t   ret_core_q;

    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;
        case (state_q)
            IDLE: begin
                if (grant_valid_i) begin
                    sel_d = grant_core_i;
                    if (pend_re_i[grant_core_i] && !pend_lr_i[grant_core_i]) begin
                        state_d = ACCESS;  // plain load
                    end else begin
                        state_d = RSVCHECK;
                    end
                end
            end
            RSVCHECK: state_d = ACCESS;
            ACCESS:   state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    assign in_rsv = (state_q == RSVCHECK);
    assign in_acc = (state_q == ACCESS);

    assign lr_set_o      = in_rsv && pend_re_i[sel_q] && pend_lr_i[sel_q];
    assign sc_check_o    = in_rsv && pend_we_i[sel_q] && pend_sc_i[sel_q];
    assign store_inval_o = in_rsv && pend_we_i[sel_q] && !pend_sc_i[sel_q];
    assign rsv_core_o    = sel_q;
    assign rsv_addr_o    = pend_addr_i[sel_q];

    assign mem_re_o    = in_acc && pend_re_i[sel_q];
    assign mem_we_o    = in_acc && pend_we_i[sel_q] && (!pend_sc_i[sel_q] || sc_ok_i);
    assign mem_addr_o  = pend_addr_i[sel_q];
    assign mem_wdata_o = pend_wdata_i[sel_q];
    assign mem_wstrb_o = pend_wstrb_i[sel_q];

    // request leaves the buffer as the memory op issues
    assign serve_o        = in_acc;
    assign serve_core_o   = sel_q;
    assign advance_o      = in_acc;
    assign advance_core_o = sel_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= IDLE;
            sel_q         <= '0;
            ret_valid_q   <= 1'b0;
            ret_core_q    <= '0;
            ret_sc_q      <= 1'b0;
            rdata_valid_o <= '0;
        end else begin
            state_q     <= state_d;
            sel_q       <= sel_d;
            ret_valid_q <= in_acc;
            if (in_acc) begin
                ret_core_q <= sel_q;
                ret_sc_q   <= pend_sc_i[sel_q];
            end
            rdata_valid_o <= '0;
            if (ret_valid_q) begin
                rdata_valid_o[ret_core_q] <= 1'b1;
            end
        end
    end

    // sc_ok_i still holds here, the lane is back in IDLE
    always_ff @(posedge clk_i) begin
        if (ret_valid_q) begin
            rdata_o[ret_core_q] <= ret_sc_q ? word_t'(!sc_ok_i) : mem_rdata_i;
        end
    end

endmodule

//--- rtl/core_req_buffer.sv
`timescale 1ns/100ps

module core_req_buffer (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    input  logic [dbus_pkg::NCORES-1:0]            re_i,
    input  logic [dbus_pkg::NCORES-1:0]            we_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] addr_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] wdata_i,
    input  dbus_pkg::strb_t [dbus_pkg::NCORES-1:0] wstrb_i,
    input  logic [dbus_pkg::NCORES-1:0]            is_lr_i,
    input  logic [dbus_pkg::NCORES-1:0]            is_sc_i,
    input  logic                                   serve_i,
    input  dbus_pkg::core_idx_t                    serve_core_i,
    output logic [dbus_pkg::NCORES-1:0]            pend_valid_o,
    output logic [dbus_pkg::NCORES-1:0]            pend_re_o,
    output logic [dbus_pkg::NCORES-1:0]            pend_we_o,
    output dbus_pkg::word_t [dbus_pkg::NCORES-1:0] pend_addr_o,
    output dbus_pkg::word_t [dbus_pkg::NCORES-1:0] pend_wdata_o,
    output dbus_pkg::strb_t [dbus_pkg::NCORES-1:0] pend_wstrb_o,
    output logic [dbus_pkg::NCORES-1:0]            pend_lr_o,
    output logic [dbus_pkg::NCORES-1:0]            pend_sc_o,
    output logic [dbus_pkg::NCORES-1:0]            stall_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0] load;

    // a slot only takes a new request when empty
    assign load = ~pend_valid_o & (re_i | we_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_valid_o <= '0;
            stall_o      <= '0;
        end else begin
            for (int k = 0; k < NCORES; k++) begin
                if (load[k]) begin
                    pend_valid_o[k] <= 1'b1;
                end else if (serve_i && serve_core_i == core_idx_t'(k)) begin
                    pend_valid_o[k] <= 1'b0;
                end
            end
            stall_o <= load | pend_valid_o;  // covers the return cycle after serve
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NCORES; k++) begin
            if (load[k]) begin
                pend_re_o[k]    <= re_i[k];
                pend_we_o[k]    <= we_i[k];
                pend_addr_o[k]  <= addr_i[k];
                pend_wdata_o[k] <= wdata_i[k];
                pend_wstrb_o[k] <= wstrb_i[k];
                pend_lr_o[k]    <= is_lr_i[k];
                pend_sc_o[k]    <= is_sc_i[k];
            end
        end
    end

endmodule

//--- rtl/dbus_dmem.sv
`timescale 1ns/100ps

module dbus_dmem (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,
    input  logic [dbus_pkg::NCORES-1:0]            re_i,
    input  logic [dbus_pkg::NCORES-1:0]            we_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] addr_i,
    input  dbus_pkg::word_t [dbus_pkg::NCORES-1:0] wdata_i,
    input  dbus_pkg::strb_t [dbus_pkg::NCORES-1:0] wstrb_i,
    input  logic [dbus_pkg::NCORES-1:0]            is_lr_i,
    input  logic [dbus_pkg::NCORES-1:0]            is_sc_i,
    output dbus_pkg::word_t [dbus_pkg::NCORES-1:0] rdata_o,
    output logic [dbus_pkg::NCORES-1:0]            rdata_valid_o,
    output logic [dbus_pkg::NCORES-1:0]            stall_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0]  pend_valid;
    logic [NCORES-1:0]  pend_re;
    logic [NCORES-1:0]  pend_we;
    word_t [NCORES-1:0] pend_addr;
    word_t [NCORES-1:0] pend_wdata;
    strb_t [NCORES-1:0] pend_wstrb;
    logic [NCORES-1:0]  pend_lr;
    logic [NCORES-1:0]  pend_sc;

    logic      grant_valid;
    core_idx_t grant_core;
    logic      serve;
    core_idx_t serve_core;
    logic      advance;
    core_idx_t advance_core;

    logic      lr_set;
    logic      sc_check;
    logic      store_inval;
    core_idx_t rsv_core;
    word_t     rsv_addr;
    logic      sc_ok;

    logic  mem_re;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    strb_t mem_wstrb;
    word_t mem_rdata;

    core_req_buffer u_core_req_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .re_i        (re_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .is_lr_i     (is_lr_i),
        .is_sc_i     (is_sc_i),
        .serve_i     (serve),
        .serve_core_i(serve_core),
        .pend_valid_o(pend_valid),
        .pend_re_o   (pend_re),
        .pend_we_o   (pend_we),
        .pend_addr_o (pend_addr),
        .pend_wdata_o(pend_wdata),
        .pend_wstrb_o(pend_wstrb),
        .pend_lr_o   (pend_lr),
        .pend_sc_o   (pend_sc),
        .stall_o     (stall_o)
    );

    rr_arbiter u_rr_arbiter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .pend_valid_i  (pend_valid),
        .advance_i     (advance),
        .advance_core_i(advance_core),
        .grant_valid_o (grant_valid),
        .grant_core_o  (grant_core)
    );

    reservation_table u_reservation_table (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .lr_set_i     (lr_set),
        .sc_check_i   (sc_check),
        .store_inval_i(store_inval),
        .rsv_core_i   (rsv_core),
        .rsv_addr_i   (rsv_addr),
        .sc_ok_o      (sc_ok)
    );

    access_lane u_access_lane (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .grant_valid_i (grant_valid),
        .grant_core_i  (grant_core),
        .pend_re_i     (pend_re),
        .pend_we_i     (pend_we),
        .pend_addr_i   (pend_addr),
        .pend_wdata_i  (pend_wdata),
        .pend_wstrb_i  (pend_wstrb),
        .pend_lr_i     (pend_lr),
        .pend_sc_i     (pend_sc),
        .sc_ok_i       (sc_ok),
        .mem_rdata_i   (mem_rdata),
        .serve_o       (serve),
        .serve_core_o  (serve_core),
        .advance_o     (advance),
        .advance_core_o(advance_core),
        .lr_set_o      (lr_set),
        .sc_check_o    (sc_check),
        .store_inval_o (store_inval),
        .rsv_core_o    (rsv_core),
        .rsv_addr_o    (rsv_addr),
        .mem_re_o      (mem_re),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_wstrb_o   (mem_wstrb),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o)
    );

    dmem u_dmem (
        .clk_i  (clk_i),
        .re_i   (mem_re),
        .we_i   (mem_we),
        .addr_i (mem_addr),
        .wdata_i(mem_wdata),
        .wstrb_i(mem_wstrb),
        .rdata_o(mem_rdata)
    );

endmodule

//--- rtl/dbus_pkg.sv
package dbus_pkg;

    localparam int NCORES     = 4;
    localparam int DATA_W     = 32;  // data and address width
    localparam int STRB_W     = DATA_W / 8;
    localparam int DMEM_WORDS = 256;
    localparam int CORE_W     = $clog2(NCORES);
    localparam int MEM_AW     = $clog2(DMEM_WORDS);  // word index bits above addr[1:0]

    typedef logic [CORE_W-1:0] core_idx_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        RSVCHECK = 2'd1,  // reservation lookup or update
        ACCESS   = 2'd2
    } lane_state_t;

endpackage

//--- rtl/dmem.sv
`timescale 1ns/100ps

module dmem (
    input  logic            clk_i,
    input  logic            re_i,
    input  logic            we_i,
    input  dbus_pkg::word_t addr_i,
    input  dbus_pkg::word_t wdata_i,
    input  dbus_pkg::strb_t wstrb_i,
    output dbus_pkg::word_t rdata_o
);
    import dbus_pkg::*;

    word_t             mem_q [DMEM_WORDS];
    logic [MEM_AW-1:0] idx;

    assign idx = addr_i[MEM_AW+1:2];  // word address

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        if (re_i) begin
            rdata_o <= mem_q[idx];  // old data on same-cycle write
        end
    end

endmodule

//--- rtl/reservation_table.sv
`timescale 1ns/100ps

module reservation_table (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                lr_set_i,
    input  logic                sc_check_i,
    input  logic                store_inval_i,
    input  dbus_pkg::core_idx_t rsv_core_i,
    input  dbus_pkg::word_t     rsv_addr_i,
    output logic                sc_ok_o
);
    import dbus_pkg::*;

    logic [NCORES-1:0] rsv_valid_q;
    word_t             rsv_addr_q [NCORES];
    logic [NCORES-1:0] hit;
    logic              own_hit;
    logic              clear_hits;

    always_comb begin
        for (int k = 0; k < NCORES; k++) begin
            hit[k] = rsv_valid_q[k] && (rsv_addr_q[k] == rsv_addr_i);
        end
    end

    assign own_hit = hit[rsv_core_i];

    // a store or a winning SC kills every reservation on that address
    assign clear_hits = store_inval_i || (sc_check_i && own_hit);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsv_valid_q <= '0;
            sc_ok_o     <= 1'b0;
        end else begin
            if (sc_check_i) begin
                sc_ok_o <= own_hit;  // held until the next SC
            end
            if (clear_hits) begin
                rsv_valid_q <= rsv_valid_q & ~hit;
            end else if (lr_set_i) begin
                rsv_valid_q[rsv_core_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lr_set_i) begin
            rsv_addr_q[rsv_core_i] <= rsv_addr_i;
        end
    end

endmodule

//--- rtl/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [dbus_pkg::NCORES-1:0] pend_valid_i,
    input  logic                        advance_i,
    input  dbus_pkg::core_idx_t         advance_core_i,
    output logic                        grant_valid_o,
    output dbus_pkg::core_idx_t         grant_core_o
);
    import dbus_pkg::*;

    core_idx_t ptr_q;  // highest priority core

    // walk from the far end so the core nearest the pointer wins
    always_comb begin
        core_idx_t idx;
        grant_valid_o = 1'b0;
        grant_core_o  = ptr_q;
        for (int i = NCORES - 1; i >= 0; i--) begin
            idx = core_idx_t'((int'(ptr_q) + i) % NCORES);
            if (pend_valid_i[idx]) begin
                grant_valid_o = 1'b1;
                grant_core_o  = idx;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (advance_i) begin
            if (advance_core_i == core_idx_t'(NCORES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= advance_core_i + 1'b1;
            end
        end
    end

endmodule

//--- test/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int RST_CYCLES = 16;

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;  // release on an edge, seen next cycle
    end

    always #5 clk_o = ~clk_o;  // 10 ns period

endmodule

//--- test/dbus_dmem_assert.sv
`timescale 1ns/100ps

module dbus_dmem_assert (
    input logic                        clk_i,
    input logic                        arst_n_i,
    input logic [dbus_pkg::NCORES-1:0] re_i,
    input logic [dbus_pkg::NCORES-1:0] we_i,
    input logic [dbus_pkg::NCORES-1:0] pend_valid_i,
    input logic [dbus_pkg::NCORES-1:0] stall_i,
    input logic [dbus_pkg::NCORES-1:0] rdata_valid_i
);
    import dbus_pkg::*;

    a_valid_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(rdata_valid_i))
        else $error("rdata_valid_o has more than one bit set");

    for (genvar k = 0; k < NCORES; k++) begin : g_core
        // a fresh request shows up as stall one cycle later
        a_stall_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            (re_i[k] || we_i[k]) && !pend_valid_i[k] |=> stall_i[k])
            else $error("stall_o[%0d] did not rise after a request", k);

        a_valid_after_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            rdata_valid_i[k] |-> $past(stall_i[k]))
            else $error("rdata_valid_o[%0d] without stall_o the cycle before", k);
    end

endmodule

bind dbus_dmem dbus_dmem_assert u_dbus_dmem_assert (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .re_i         (re_i),
    .we_i         (we_i),
    .pend_valid_i (pend_valid),
    .stall_i      (stall_o),
    .rdata_valid_i(rdata_valid_o)
);

//--- test/tb_dbus_dmem.sv
`timescale 1ns/100ps

module tb_dbus_dmem;
    import dbus_pkg::*;

    localparam int N_REQS          = 33;  // requests issued over all tests
    localparam int CYCLES_PER_REQ  = 200;
    localparam int WATCHDOG_CYCLES = 16 + N_REQS * CYCLES_PER_REQ;
    localparam int SEED            = 32'h8d498941;

    logic               clk;
    logic               arst_n;
    logic [NCORES-1:0]  re;
    logic [NCORES-1:0]  we;
    word_t [NCORES-1:0] addr;
    word_t [NCORES-1:0] wdata;
    strb_t [NCORES-1:0] wstrb;
    logic [NCORES-1:0]  is_lr;
    logic [NCORES-1:0]  is_sc;
    word_t [NCORES-1:0] rdata;
    logic [NCORES-1:0]  rdata_valid;
    logic [NCORES-1:0]  stall;

    int    checks;
    int    errors;
    int    valid_cnt [NCORES];
    word_t valid_data [NCORES];

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    dbus_dmem u_dbus_dmem (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .re_i         (re),
        .we_i         (we),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .wstrb_i      (wstrb),
        .is_lr_i      (is_lr),
        .is_sc_i      (is_sc),
        .rdata_o      (rdata),
        .rdata_valid_o(rdata_valid),
        .stall_o      (stall)
    );

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // one-cycle request, then wait for this core's return pulse
    task automatic request(input core_idx_t c, input logic rd, input logic wr, input logic lr,
                           input logic sc, input word_t a, input word_t d, input strb_t s,
                           output word_t got);
        @(posedge clk);
        re[c]    <= rd;
        we[c]    <= wr;
        is_lr[c] <= lr;
        is_sc[c] <= sc;
        addr[c]  <= a;
        wdata[c] <= d;
        wstrb[c] <= s;
        @(posedge clk);
        re[c]    <= 1'b0;
        we[c]    <= 1'b0;
        is_lr[c] <= 1'b0;
        is_sc[c] <= 1'b0;
        do @(negedge clk); while (!rdata_valid[c]);
        got = rdata[c];
    endtask

    task automatic store(input core_idx_t c, input word_t a, input word_t d, input strb_t s);
        word_t unused;
        request(c, 1'b0, 1'b1, 1'b0, 1'b0, a, d, s, unused);
    endtask

    task automatic load(input core_idx_t c, input word_t a, input logic lr, output word_t got);
        request(c, 1'b1, 1'b0, lr, 1'b0, a, '0, '0, got);
    endtask

    task automatic store_cond(input core_idx_t c, input word_t a, input word_t d,
                              output word_t got);
        request(c, 1'b0, 1'b1, 1'b0, 1'b1, a, d, '1, got);
    endtask

    function automatic bit all_returned();
        for (int k = 0; k < NCORES; k++) begin
            if (valid_cnt[k] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic count_returns();
        for (int k = 0; k < NCORES; k++) begin
            if (rdata_valid[k]) begin
                valid_cnt[k]++;
                valid_data[k] = rdata[k];
            end
        end
    endtask

    // a few extra cycles catch duplicate pulses
    task automatic collect_returns();
        for (int k = 0; k < NCORES; k++) begin
            valid_cnt[k] = 0;
        end
        while (!all_returned()) begin
            @(negedge clk);
            count_returns();
        end
        repeat (8) begin
            @(negedge clk);
            count_returns();
        end
    endtask

    task automatic test_store_load();
        word_t got;
        word_t pat;
        word_t base;
        word_t part;
        for (int k = 0; k < NCORES; k++) begin
            pat = $urandom();
            store(core_idx_t'(k), 32'h40 + 4 * k, pat, 4'hf);
            load(core_idx_t'(k), 32'h40 + 4 * k, 1'b0, got);
            check_word($sformatf("rdata_o[%0d]", k), got, pat);
        end
        base = $urandom();
        part = $urandom();
        store(2'd0, 32'h80, base, 4'hf);
        store(2'd0, 32'h80, part, 4'b0101);
        load(2'd0, 32'h80, 1'b0, got);
        // bytes 0 and 2 come from the partial store
        check_word("rdata_o[0]", got, {base[31:24], part[23:16], base[15:8], part[7:0]});
    endtask

    task automatic test_lr_sc_pass();
        word_t got;
        word_t init;
        word_t pat;
        init = $urandom();
        pat  = $urandom();
        store(2'd1, 32'h180, init, 4'hf);
        load(2'd1, 32'h180, 1'b1, got);
        check_word("rdata_o[1]", got, init);
        store_cond(2'd1, 32'h180, pat, got);
        check_word("rdata_o[1]", got, 32'd0);
        load(2'd1, 32'h180, 1'b0, got);
        check_word("rdata_o[1]", got, pat);
    endtask

    task automatic test_sc_no_rsv();
        word_t got;
        word_t init;
        init = $urandom();
        store(2'd3, 32'h1c0, init, 4'hf);
        store_cond(2'd3, 32'h1c0, ~init, got);
        check_word("rdata_o[3]", got, 32'd1);
        load(2'd3, 32'h1c0, 1'b0, got);
        check_word("rdata_o[3]", got, init);
    endtask

    task automatic test_rsv_kill();
        word_t got;
        word_t init;
        word_t other;
        init  = $urandom();
        other = $urandom();
        store(2'd0, 32'h200, init, 4'hf);
        load(2'd0, 32'h200, 1'b1, got);
        check_word("rdata_o[0]", got, init);
        store(2'd1, 32'h200, other, 4'hf);  // breaks core 0's reservation
        store_cond(2'd0, 32'h200, ~other, got);
        check_word("rdata_o[0]", got, 32'd1);
        load(2'd2, 32'h200, 1'b0, got);
        check_word("rdata_o[2]", got, other);
        store_cond(2'd0, 32'h200, ~other, got);
        check_word("rdata_o[0]", got, 32'd1);
        load(2'd2, 32'h200, 1'b0, got);
        check_word("rdata_o[2]", got, other);
    endtask

    task automatic test_parallel();
        word_t pat [NCORES];
        for (int k = 0; k < NCORES; k++) begin
            pat[k] = $urandom();
        end
        @(posedge clk);
        for (int k = 0; k < NCORES; k++) begin
            we[k]    <= 1'b1;
            addr[k]  <= 32'h300 + 4 * k;
            wdata[k] <= pat[k];
            wstrb[k] <= '1;
        end
        @(posedge clk);
        we <= '0;
        @(negedge clk);
        for (int k = 0; k < NCORES; k++) begin
            check_bit($sformatf("stall_o[%0d]", k), stall[k], 1'b1);
        end
        collect_returns();
        for (int k = 0; k < NCORES; k++) begin
            check_bit($sformatf("single store pulse on rdata_valid_o[%0d]", k),
                      valid_cnt[k] == 1, 1'b1);
        end
        @(posedge clk);
        re <= '1;
        @(posedge clk);
        re <= '0;
        collect_returns();
        for (int k = 0; k < NCORES; k++) begin
            check_bit($sformatf("single load pulse on rdata_valid_o[%0d]", k),
                      valid_cnt[k] == 1, 1'b1);
            check_word($sformatf("rdata_o[%0d]", k), valid_data[k], pat[k]);
        end
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int seed_val;
        int mark;
        seed_val = $urandom(SEED);
        checks   = 0;
        errors   = 0;
        re       = '0;
        we       = '0;
        addr     = '0;
        wdata    = '0;
        wstrb    = '0;
        is_lr    = '0;
        is_sc    = '0;
        wait (arst_n === 1'b1);
        @(posedge clk);

        mark = errors;
        test_store_load();
        report("store_load", mark);
        mark = errors;
        test_lr_sc_pass();
        report("lr_sc_pass", mark);
        mark = errors;
        test_sc_no_rsv();
        report("sc_no_rsv", mark);
        mark = errors;
        test_rsv_kill();
        report("rsv_kill", mark);
        mark = errors;
        test_parallel();
        report("parallel", mark);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a request never returned",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule
